/* hw/posit_pkg.sv */
package posit_pkg;

    //////////////////////////////
    // word format
    //////////////////////////////

    // posit16, one exponent bit
    localparam int posit_n  = 16;
    localparam int posit_es = 1;

    // regime count, also wide enough for any shift in the datapath
    localparam int posit_rs = $clog2(posit_n) + 1;

    // combined scale = regime * 2^es + exponent, signed
    localparam int scale_w  = 7;

    // hidden bit plus fraction field
    localparam int frac_w   = posit_n - posit_es - 2;

    // carry, fraction, guard, round, sticky
    localparam int sum_w    = frac_w + 4;

    typedef logic [posit_n-1:0] posit_t;

    // operand class from decode
    typedef enum logic [1:0]
    {
        class_zero,
        class_nar,
        class_normal
    } posit_class_e;

    //////////////////////////////
    // special words
    //////////////////////////////

    localparam posit_t posit_nar    = {1'b1, {(posit_n-1){1'b0}}};
    localparam posit_t posit_maxpos = {1'b0, {(posit_n-1){1'b1}}};
    localparam posit_t posit_minpos = {{(posit_n-1){1'b0}}, 1'b1};

endpackage

/* hw/posit_decode.sv */
`timescale 1ns/100ps

module posit_decode (
    input  posit_pkg::posit_t                    word,
    output posit_pkg::posit_class_e              pclass,
    output logic                                 sign,
    output logic signed [posit_pkg::scale_w-1:0] scale,
    output logic        [posit_pkg::frac_w-1:0]  frac
);
    import posit_pkg::*;

    posit_t                    mag;
    logic [posit_n-2:0]        body;
    logic [posit_n-2:0]        rest;
    logic [posit_rs-1:0]       run;
    logic                      run_done;
    logic signed [scale_w-1:0] regime;
    logic [posit_es-1:0]       exp_bits;

    always_comb
    begin
        // class straight off the raw word
        if (word == '0)
            pclass = class_zero;
        else if (word == posit_nar)
            pclass = class_nar;
        else
            pclass = class_normal;

        sign = word[posit_n-1];

        // negative words are stored in two's complement
        mag  = sign ? -word : word;
        body = mag[posit_n-2:0];

        // regime run length, counting the first bit
        run      = 1;
        run_done = 1'b0;
        for (int i = posit_n - 3; i >= 0; i--)
        begin
            if (!run_done && body[i] == body[posit_n-2])
                run = run + 1'b1;
            else
                run_done = 1'b1;
        end

        // drop run and terminating bit
        rest = body << (run + 1'b1);

        // ones give k = run - 1, zeros give k = -run
        regime = scale_w'(run);
        if (body[posit_n-2])
            regime = regime - 1;
        else
            regime = -regime;

        exp_bits = rest[posit_n-2 -: posit_es];
        scale    = (regime <<< posit_es) + signed'({1'b0, exp_bits});

        // bits past the end of the word read as zero
        frac = {1'b1, rest[posit_n-2-posit_es -: frac_w-1]};
    end

endmodule

/* hw/posit_align_add.sv */
`timescale 1ns/100ps

module posit_align_add (
    input  logic                                 a_sign,
    input  logic                                 b_sign,
    input  logic signed [posit_pkg::scale_w-1:0] a_scale,
    input  logic signed [posit_pkg::scale_w-1:0] b_scale,
    input  logic        [posit_pkg::frac_w-1:0]  a_frac,
    input  logic        [posit_pkg::frac_w-1:0]  b_frac,
    output logic                                 sum_sign,
    output logic signed [posit_pkg::scale_w-1:0] sum_scale,
    output logic        [posit_pkg::sum_w-1:0]   sum_raw
);
    import posit_pkg::*;

    logic                      a_first;
    logic signed [scale_w-1:0] small_scale;
    logic [frac_w-1:0]         big_frac;
    logic [frac_w-1:0]         small_frac;
    logic                      eff_sub;
    logic [scale_w-1:0]        shamt;
    logic [frac_w+1:0]         small_gr;
    logic [frac_w+1:0]         lost_mask;
    logic                      sticky;
    logic [sum_w-1:0]          big_al;
    logic [sum_w-1:0]          small_al;
    logic [sum_w:0]            sum_ext;

    //////////////////////////////
    // order by magnitude
    //////////////////////////////

    always_comb
    begin
        a_first = (a_scale > b_scale) || ((a_scale == b_scale) && (a_frac >= b_frac));

        sum_sign    = a_first ? a_sign  : b_sign;
        sum_scale   = a_first ? a_scale : b_scale;
        small_scale = a_first ? b_scale : a_scale;
        big_frac    = a_first ? a_frac  : b_frac;
        small_frac  = a_first ? b_frac  : a_frac;

        eff_sub = a_sign ^ b_sign;

        // never negative, so read as unsigned
        shamt = sum_scale - small_scale;
    end

    //////////////////////////////
    // align and add
    //////////////////////////////

    always_comb
    begin
        // guard and round slots below the smaller fraction
        small_gr  = {small_frac, 2'b00};
        lost_mask = ~({(frac_w+2){1'b1}} << shamt);
        sticky    = |(small_gr & lost_mask);

        // carry | fraction | g r s
        big_al   = {1'b0, big_frac, {(sum_w-frac_w-1){1'b0}}};
        small_al = {1'b0, (small_gr >> shamt), sticky};

        // low bit of big_al is zero, so a borrow from sticky leaves bit 0 set
        if (eff_sub)
            sum_ext = {1'b0, big_al} - {1'b0, small_al};
        else
            sum_ext = {1'b0, big_al} + {1'b0, small_al};

        sum_raw = sum_ext[sum_w-1:0];

        // larger operand first, so no borrow out and no carry past bit sum_w-1
        assert final ($isunknown(sum_ext) || !sum_ext[sum_w])
            else $error("align_add: raw sum out of range %h", sum_ext);
    end

endmodule

/* hw/posit_normalize.sv */
`timescale 1ns/100ps

module posit_normalize (
    input  logic signed [posit_pkg::scale_w-1:0] sum_scale,
    input  logic        [posit_pkg::sum_w-1:0]   sum_raw,
    output logic signed [posit_pkg::scale_w-1:0] norm_scale,
    output logic        [posit_pkg::sum_w-1:0]   norm_frac
);
    import posit_pkg::*;

    // up to sum_w leading zeros on a zero sum
    logic [posit_rs-1:0] lz;
    logic                lz_done;

    always_comb
    begin
        // leading zero count from the carry bit down
        lz      = '0;
        lz_done = 1'b0;
        for (int i = sum_w - 1; i >= 0; i--)
        begin
            if (!lz_done && !sum_raw[i])
                lz = lz + 1'b1;
            else
                lz_done = 1'b1;
        end

        // hidden bit to the top
        // left shift only, so the sticky bit just moves up
        norm_frac = sum_raw << lz;

        // the raw hidden bit sits one below the top
        // carry gives lz = 0 and +1, a plain sum gives lz = 1 and no change
        norm_scale = sum_scale + 1 - signed'(scale_w'(lz));
    end

endmodule

/* hw/posit_round_encode.sv */
`timescale 1ns/100ps

module posit_round_encode (
    input  posit_pkg::posit_t                    a_word,
    input  posit_pkg::posit_t                    b_word,
    input  posit_pkg::posit_class_e              a_class,
    input  posit_pkg::posit_class_e              b_class,
    input  logic                                 sum_sign,
    input  logic signed [posit_pkg::scale_w-1:0] norm_scale,
    input  logic        [posit_pkg::sum_w-1:0]   norm_frac,
    output posit_pkg::posit_t                    result
);
    import posit_pkg::*;

    logic signed [scale_w-1:0]          regime;
    logic [posit_es-1:0]                exp_bits;
    logic                               run_bit;
    logic [posit_rs-1:0]                run_len;
    logic [posit_n+posit_es+sum_w-1:0]  build;
    logic [posit_n-2:0]                 kept;
    logic                               guard;
    logic                               rnd;
    logic                               sticky;
    logic                               round_up;
    posit_t                             mag;
    posit_t                             enc;

    //////////////////////////////
    // regime, exponent, fraction
    //////////////////////////////

    always_comb
    begin
        regime   = norm_scale >>> posit_es;
        exp_bits = norm_scale[posit_es-1:0];

        // ones for k >= 0, zeros for k < 0
        run_bit = !regime[scale_w-1];

        if (run_bit)
        begin
            if (regime >= posit_n - 1)
                run_len = posit_rs'(posit_n);
            else
                run_len = posit_rs'(regime + 1);
        end
        else
        begin
            if (regime <= -posit_n)
                run_len = posit_rs'(posit_n);
            else
                run_len = posit_rs'(-regime);
        end

        // full run on top, keep run_len of it
        build = {{posit_n{run_bit}}, !run_bit, exp_bits, norm_frac[sum_w-2:0]}
                << (posit_n - run_len);

        kept   = build[posit_n+posit_es+sum_w-1 -: posit_n-1];
        guard  = build[posit_es+sum_w];
        rnd    = build[posit_es+sum_w-1];
        sticky = |build[posit_es+sum_w-2:0];
    end

    //////////////////////////////
    // round, clamp, sign
    //////////////////////////////

    always_comb
    begin
        // nearest, ties to even on the word itself
        round_up = guard & (kept[0] | rnd | sticky);
        mag      = {1'b0, kept} + round_up;

        // past maxpos, saturate before rounding can reach NaR
        if (regime >= posit_n - 2)
            mag = posit_maxpos;
        // never round to zero
        else if (mag == '0)
            mag = posit_minpos;

        enc = sum_sign ? -mag : mag;

        // special cases
        if (a_class == class_nar || b_class == class_nar)
            result = posit_nar;
        else if (a_class == class_zero)
            result = b_word;
        else if (b_class == class_zero)
            result = a_word;
        else if (norm_frac == '0)
            result = '0;
        else
            result = enc;

        // two normal operands that do not cancel give a normal word
        assert final ($isunknown({a_class, b_class, norm_frac, result})
                      || a_class != class_normal || b_class != class_normal
                      || norm_frac == '0
                      || (result != '0 && result != posit_nar))
            else $error("round_encode: normal sum encoded as %h", result);
    end

endmodule

/* hw/posit_adder.sv */
`timescale 1ns/100ps

module posit_adder (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  posit_pkg::posit_t a,
    input  posit_pkg::posit_t b,
    output logic              out_valid,
    output posit_pkg::posit_t sum
);
    import posit_pkg::*;

    // decode outputs
    posit_class_e              a_class_d;
    posit_class_e              b_class_d;
    logic                      a_sign_d;
    logic                      b_sign_d;
    logic signed [scale_w-1:0] a_scale_d;
    logic signed [scale_w-1:0] b_scale_d;
    logic [frac_w-1:0]         a_frac_d;
    logic [frac_w-1:0]         b_frac_d;

    // stage 1
    posit_t                    a_word_q;
    posit_t                    b_word_q;
    posit_class_e              a_class_q;
    posit_class_e              b_class_q;
    logic                      a_sign_q;
    logic                      b_sign_q;
    logic signed [scale_w-1:0] a_scale_q;
    logic signed [scale_w-1:0] b_scale_q;
    logic [frac_w-1:0]         a_frac_q;
    logic [frac_w-1:0]         b_frac_q;

    // stage 2 datapath
    logic                      add_sign;
    logic signed [scale_w-1:0] add_scale;
    logic [sum_w-1:0]          add_raw;
    logic signed [scale_w-1:0] norm_scale;
    logic [sum_w-1:0]          norm_frac;
    posit_t                    enc_word;

    // valid pipe, one bit per stage
    logic [1:0]                vld_q;

    //////////////////////////////
    // stage 1, decode
    //////////////////////////////

    posit_decode u_dec_a (
        .word   (a),
        .pclass (a_class_d),
        .sign   (a_sign_d),
        .scale  (a_scale_d),
        .frac   (a_frac_d)
    );

    posit_decode u_dec_b (
        .word   (b),
        .pclass (b_class_d),
        .sign   (b_sign_d),
        .scale  (b_scale_d),
        .frac   (b_frac_d)
    );

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            a_word_q  <= '0;
            b_word_q  <= '0;
            a_class_q <= class_zero;
            b_class_q <= class_zero;
            a_sign_q  <= 1'b0;
            b_sign_q  <= 1'b0;
            a_scale_q <= '0;
            b_scale_q <= '0;
            a_frac_q  <= '0;
            b_frac_q  <= '0;
        end
        else if (in_valid)
        begin
            a_word_q  <= a;
            b_word_q  <= b;
            a_class_q <= a_class_d;
            b_class_q <= b_class_d;
            a_sign_q  <= a_sign_d;
            b_sign_q  <= b_sign_d;
            a_scale_q <= a_scale_d;
            b_scale_q <= b_scale_d;
            a_frac_q  <= a_frac_d;
            b_frac_q  <= b_frac_d;
        end
    end

    //////////////////////////////
    // stage 2, add and encode
    //////////////////////////////

    posit_align_add u_add (
        .a_sign    (a_sign_q),
        .b_sign    (b_sign_q),
        .a_scale   (a_scale_q),
        .b_scale   (b_scale_q),
        .a_frac    (a_frac_q),
        .b_frac    (b_frac_q),
        .sum_sign  (add_sign),
        .sum_scale (add_scale),
        .sum_raw   (add_raw)
    );

    posit_normalize u_norm (
        .sum_scale  (add_scale),
        .sum_raw    (add_raw),
        .norm_scale (norm_scale),
        .norm_frac  (norm_frac)
    );

    posit_round_encode u_enc (
        .a_word     (a_word_q),
        .b_word     (b_word_q),
        .a_class    (a_class_q),
        .b_class    (b_class_q),
        .sum_sign   (add_sign),
        .norm_scale (norm_scale),
        .norm_frac  (norm_frac),
        .result     (enc_word)
    );

    // output register, holds the last result between strobes
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            vld_q <= 2'b00;
            sum   <= '0;
        end
        else
        begin
            vld_q <= {vld_q[0], in_valid};
            if (vld_q[0])
                sum <= enc_word;
        end
    end

    assign out_valid = vld_q[1];

    // fixed two cycle latency, both directions
    a_lat_fwd: assert property (@(posedge clk) disable iff (!rst_n)
                                in_valid |-> ##2 out_valid);
    a_lat_bwd: assert property (@(posedge clk) disable iff (!rst_n)
                                out_valid |-> $past(in_valid, 2));

endmodule

/* dv/posit_ref_model.svh */
`ifndef POSIT_REF_MODEL_SVH
`define POSIT_REF_MODEL_SVH

//////////////////////////////
// exact posit16 es=1 model
//////////////////////////////

// normal word only, value = (-1)^sign * mant * 2^(scale - 12)
function automatic void model_decode(input posit_t w, output logic sign,
                                     output int scale, output logic [12:0] mant);
    posit_t      mag;
    logic [14:0] body;
    int          m;
    int          k;
    int          e;
    int          left;
    sign = w[15];
    mag  = sign ? -w : w;
    body = mag[14:0];
    // regime run from the top of the body
    m = 1;
    while (m < 15 && body[14-m] == body[14])
        m++;
    k = body[14] ? m - 1 : -m;
    // bits after the run and its terminating bit
    left = 14 - m;
    e    = 0;
    mant = 13'h1000;
    if (left >= 1)
        e = body[left-1];
    for (int i = 0; i < 12; i++)
    begin
        if (left - 2 - i >= 0)
            mant[11-i] = body[left-2-i];
    end
    scale = 2 * k + e;
endfunction

// value = (-1)^sign * mag * 2^lsb_scale, mag nonzero
function automatic posit_t model_encode(input logic sign, input logic [127:0] mag,
                                        input int lsb_scale);
    int           p;
    int           scale;
    int           k;
    int           len;
    logic [127:0] bits;
    logic [14:0]  kept;
    logic         guard;
    logic         sticky;
    posit_t       word;
    p = 127;
    while (!mag[p])
        p--;
    scale = p + lsb_scale;
    k     = scale >>> 1;
    if (k >= 14)
        word = posit_maxpos;
    else if (k < -14)
        word = posit_minpos;
    else
    begin
        // regime run plus terminating bit
        if (k >= 0)
        begin
            bits = ((128'd1 << (k + 1)) - 1) << 1;
            len  = k + 2;
        end
        else
        begin
            bits = 128'd1;
            len  = 1 - k;
        end
        // exponent bit, then every fraction bit of the exact sum
        bits = (bits << 1) | 128'(scale - 2 * k);
        len  = len + 1;
        bits = (bits << p) | (mag & ((128'd1 << p) - 1));
        len  = len + p;
        guard  = 1'b0;
        sticky = 1'b0;
        if (len <= 15)
            kept = 15'(bits << (15 - len));
        else
        begin
            kept   = 15'(bits >> (len - 15));
            guard  = bits[len-16];
            sticky = |(bits & ((128'd1 << (len - 16)) - 1));
        end
        // ties to even on the word
        word = {1'b0, kept} + 16'(guard & (kept[0] | sticky));
        if (word == '0)
            word = posit_minpos;
    end
    return sign ? -word : word;
endfunction

function automatic posit_t model_add(input posit_t x, input posit_t y);
    logic               xs;
    logic               ys;
    int                 xsc;
    int                 ysc;
    int                 lo;
    logic [12:0]        xm;
    logic [12:0]        ym;
    logic signed [127:0] xv;
    logic signed [127:0] yv;
    logic signed [127:0] total;
    if (x == posit_nar || y == posit_nar)
        return posit_nar;
    if (x == '0)
        return y;
    if (y == '0)
        return x;
    model_decode(x, xs, xsc, xm);
    model_decode(y, ys, ysc, ym);
    // common lsb at the smaller scale
    lo = (xsc < ysc) ? xsc : ysc;
    xv = 128'(xm) << (xsc - lo);
    yv = 128'(ym) << (ysc - lo);
    if (xs)
        xv = -xv;
    if (ys)
        yv = -yv;
    total = xv + yv;
    if (total == 0)
        return '0;
    return model_encode(total < 0, (total < 0) ? -total : total, lo - 12);
endfunction

`endif

/* dv/posit_adder_tb.sv */
`timescale 1ns/100ps

module posit_adder_tb;
    import posit_pkg::*;

    localparam int num_tests  = 4000;
    localparam int clk_period = 4;

    logic   clk;
    logic   rst_n;
    logic   in_valid;
    posit_t a;
    posit_t b;
    logic   out_valid;
    posit_t sum;

    integer      seed;
    int          sum_errors;
    int          valid_errors;
    int          other_errors;
    posit_t      expect_q[$];
    // driven valid, seen on out_valid two falling edges later
    logic [1:0]  valid_pipe;

    `include "posit_ref_model.svh"

    posit_adder uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .sum       (sum)
    );

    always #(clk_period / 2) clk = ~clk;

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_posit(input string name, input posit_t got, input posit_t exp);
        if (got !== exp)
        begin
            sum_errors++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp)
        begin
            valid_errors++;
            $display("Mismatch at %0t ns: out_valid got %b expected %b", $time, got, exp);
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    // random words with directed special cases mixed in
    task automatic pick_operands(output posit_t x, output posit_t y);
        logic [31:0] r;
        logic [31:0] w;
        r = $random(seed);
        w = $random(seed);
        x = w[15:0];
        y = w[31:16];
        case (r[3:0])
            4'd0: x = '0;
            4'd1: y = '0;
            4'd2: x = posit_nar;
            4'd3: y = posit_nar;
            4'd4: y = -x;
            4'd5:
            begin
                x = posit_maxpos;
                y = posit_maxpos;
            end
            4'd6:
            begin
                x = posit_maxpos;
                y = {8'h7f, r[15:8]};
            end
            4'd7:
            begin
                // near minpos, either sign
                x = posit_minpos;
                y = {12'h000, r[7:4]};
                if (r[8])
                    y = -y;
            end
            4'd8:
            begin
                x = -posit_minpos;
                y = {12'h000, r[7:4]};
            end
            default: ;
        endcase
    endtask

    // one falling edge: check outputs, then drive the next inputs
    task automatic step(input logic v, input posit_t x, input posit_t y);
        posit_t exp_sum;
        @(negedge clk);
        check_valid(out_valid, valid_pipe[1]);
        if (out_valid === 1'b1)
        begin
            if (expect_q.size() == 0)
            begin
                other_errors++;
                $display("error at %0t ns: out_valid high with no result pending", $time);
            end
            else
            begin
                exp_sum = expect_q.pop_front();
                check_posit("sum", sum, exp_sum);
            end
        end
        in_valid = v;
        a        = x;
        b        = y;
        if (v)
            expect_q.push_back(model_add(x, y));
        valid_pipe = {valid_pipe[0], v};
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial
    begin
        logic [31:0] r;
        posit_t      x;
        posit_t      y;
        seed         = 32'h5a6d;
        sum_errors   = 0;
        valid_errors = 0;
        other_errors = 0;
        valid_pipe   = 2'b00;
        clk          = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        a            = '0;
        b            = '0;

        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        // outputs cleared by reset
        check_valid(out_valid, 1'b0);
        check_posit("sum", sum, '0);

        // about 75 percent valid density
        for (int i = 0; i < num_tests; i++)
        begin
            r = $random(seed);
            pick_operands(x, y);
            step(r[1:0] != 2'b00, x, y);
        end

        // drain until every result is back
        while (expect_q.size() != 0)
            step(1'b0, '0, '0);

        $display("errors: sum %0d, out_valid %0d, other %0d",
                 sum_errors, valid_errors, other_errors);
        if (sum_errors + valid_errors + other_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // watchdog, test length plus margin
    initial
    begin
        #((num_tests + 20) * clk_period);
        $display("timeout: run did not finish within %0d ns",
                 (num_tests + 20) * clk_period);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* project.f */
+incdir+dv
hw/posit_pkg.sv
hw/posit_decode.sv
hw/posit_align_add.sv
hw/posit_normalize.sv
hw/posit_round_encode.sv
hw/posit_adder.sv
dv/posit_adder_tb.sv

/* Makefile */
VERILATOR  ?= verilator
FILELIST   ?= project.f
TB_TOP     ?= posit_adder_tb
RTL_TOP    ?= posit_adder
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --timing -Wall
SIM_FLAGS  ?= --timing --assert -Wno-fatal
PASS_TEXT  ?= === PASS ===

SOURCES := $(wildcard hw/*.sv dv/*.sv dv/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -qxF -- "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
